// ==== design/io_bus_pkg.sv ====
// I/O bus shared definitions
`default_nettype none

package io_bus_pkg;

   // ************************************************************
   // Bus widths
   // ************************************************************
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;
   localparam int ID_W   = 4;
   localparam int GPIO_W = 32;

   // Page select in address bits 15:12
   localparam logic [3:0] TGT_SYS_PAGE  = 4'd0;
   localparam logic [3:0] TGT_GPIO_PAGE = 4'd1;

   // Word offsets in address bits 5:2
   localparam logic [3:0] SYS_VERSION_OFS = 4'd0;
   localparam logic [3:0] SYS_SCRATCH_OFS = 4'd1;
   localparam logic [3:0] SYS_STATUS_OFS  = 4'd2;

   localparam logic [3:0] GPIO_IN_OFS  = 4'd0;
   localparam logic [3:0] GPIO_OUT_OFS = 4'd1;
   localparam logic [3:0] GPIO_OE_OFS  = 4'd2;

   localparam logic [31:0] SYS_VERSION = 32'h0001_0203;

   // ************************************************************
   // Types
   // ************************************************************
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } axi_resp_e;

   typedef enum logic [1:0] {ST_IDLE, ST_WB, ST_RESP} bridge_state_e;

   typedef enum logic [1:0] {TGT_SYS, TGT_GPIO, TGT_NONE} target_e;

endpackage

`default_nettype wire

// ==== design/wb_if.sv ====
// Wishbone bus interface
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
   import io_bus_pkg::*;

   logic [ADDR_W-1:0] adr;
   logic [DATA_W-1:0] dat;
   logic [SEL_W-1:0]  sel;
   logic              we;
   logic              cyc;
   logic              stb;
   logic [DATA_W-1:0] rdt;
   logic              ack;
   logic              err;

   modport initiator (output adr, dat, sel, we, cyc, stb,
                      input  rdt, ack, err);

   modport responder (input  adr, dat, sel, we, cyc, stb,
                      output rdt, ack, err);

   // Register targets never signal an error
   modport target    (input  adr, dat, sel, we, cyc, stb,
                      output rdt, ack);

endinterface

`default_nettype wire

// ==== design/axi_to_wb.sv ====
// AXI to Wishbone bridge
`timescale 1ns/1ps
`default_nettype none

module axi_to_wb (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic [io_bus_pkg::ADDR_W-1:0] i_awaddr,
   input  logic [io_bus_pkg::ID_W-1:0]   i_awid,
   input  logic                         i_awvalid,
   output logic                         o_awready,
   input  logic [io_bus_pkg::DATA_W-1:0] i_wdata,
   input  logic [io_bus_pkg::SEL_W-1:0]  i_wstrb,
   input  logic                         i_wvalid,
   output logic                         o_wready,
   output logic [io_bus_pkg::ID_W-1:0]   o_bid,
   output io_bus_pkg::axi_resp_e        o_bresp,
   output logic                         o_bvalid,
   input  logic                         i_bready,
   input  logic [io_bus_pkg::ADDR_W-1:0] i_araddr,
   input  logic [io_bus_pkg::ID_W-1:0]   i_arid,
   input  logic                         i_arvalid,
   output logic                         o_arready,
   output logic [io_bus_pkg::DATA_W-1:0] o_rdata,
   output logic [io_bus_pkg::ID_W-1:0]   o_rid,
   output io_bus_pkg::axi_resp_e        o_rresp,
   output logic                         o_rvalid,
   input  logic                         i_rready,
   wb_if.initiator                      wb
);
   import io_bus_pkg::*;

   bridge_state_e     state;
   logic              wr_go;
   logic              rd_go;
   logic              resp_done;
   logic [ADDR_W-1:0] adr_q;
   logic [DATA_W-1:0] dat_q;
   logic [SEL_W-1:0]  sel_q;
   logic              we_q;
   logic [ID_W-1:0]   id_q;
   axi_resp_e         resp_q;
   logic [DATA_W-1:0] rdata_q;

   // Write has priority when both channels are pending
   assign wr_go = (state == ST_IDLE) && i_awvalid && i_wvalid;
   assign rd_go = (state == ST_IDLE) && i_arvalid && !wr_go;

   assign o_awready = wr_go;
   assign o_wready  = wr_go;
   assign o_arready = rd_go;

   assign resp_done = (o_bvalid && i_bready) || (o_rvalid && i_rready);

   // ************************************************************
   // Control FSM
   // ************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state    <= ST_IDLE;
         o_bvalid <= 1'b0;
         o_rvalid <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_go || rd_go) begin
                  state <= ST_WB;
               end
            end
            ST_WB: begin
               if (wb.ack || wb.err) begin
                  state    <= ST_RESP;
                  o_bvalid <= we_q;
                  o_rvalid <= !we_q;
               end
            end
            ST_RESP: begin
               if (resp_done) begin
                  state    <= ST_IDLE;
                  o_bvalid <= 1'b0;
                  o_rvalid <= 1'b0;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge i_clk) begin
      if (wr_go) begin
         adr_q <= i_awaddr;
         dat_q <= i_wdata;
         sel_q <= i_wstrb;
         we_q  <= 1'b1;
         id_q  <= i_awid;
      end else if (rd_go) begin
         adr_q <= i_araddr;
         sel_q <= '1;
         we_q  <= 1'b0;
         id_q  <= i_arid;
      end
      if ((state == ST_WB) && (wb.ack || wb.err)) begin
         resp_q  <= wb.err ? RESP_SLVERR : RESP_OKAY;
         rdata_q <= wb.err ? '0 : wb.rdt;
      end
   end

   assign wb.adr = adr_q;
   assign wb.dat = dat_q;
   assign wb.sel = sel_q;
   assign wb.we  = we_q;
   assign wb.cyc = (state == ST_WB);
   assign wb.stb = (state == ST_WB);

   assign o_bid   = id_q;
   assign o_bresp = resp_q;
   assign o_rid   = id_q;
   assign o_rresp = resp_q;
   assign o_rdata = rdata_q;

   // ************************************************************
   // Assertions
   // ************************************************************
   a_one_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_bvalid && o_rvalid));

   a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      wb.stb |-> wb.cyc);

endmodule

`default_nettype wire

// ==== design/wb_decoder.sv ====
// Wishbone address decoder
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
   input  logic    i_clk,
   input  logic    i_rst_n,
   wb_if.responder wb_up,
   wb_if.initiator wb_sys,
   wb_if.initiator wb_gpio
);
   import io_bus_pkg::*;

   target_e tgt;
   logic    req;
   logic    err_q;

   always_comb begin
      case (wb_up.adr[ADDR_W-1 -: 4])
         TGT_SYS_PAGE:  tgt = TGT_SYS;
         TGT_GPIO_PAGE: tgt = TGT_GPIO;
         default:       tgt = TGT_NONE;
      endcase
   end

   assign req = wb_up.cyc && wb_up.stb;

   // Request fan-out, only the selected target sees cyc/stb
   assign wb_sys.adr = wb_up.adr;
   assign wb_sys.dat = wb_up.dat;
   assign wb_sys.sel = wb_up.sel;
   assign wb_sys.we  = wb_up.we;
   assign wb_sys.cyc = wb_up.cyc && (tgt == TGT_SYS);
   assign wb_sys.stb = wb_up.stb && (tgt == TGT_SYS);

   assign wb_gpio.adr = wb_up.adr;
   assign wb_gpio.dat = wb_up.dat;
   assign wb_gpio.sel = wb_up.sel;
   assign wb_gpio.we  = wb_up.we;
   assign wb_gpio.cyc = wb_up.cyc && (tgt == TGT_GPIO);
   assign wb_gpio.stb = wb_up.stb && (tgt == TGT_GPIO);

   // Unmapped page gets a one-cycle error pulse
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req && (tgt == TGT_NONE) && !err_q;
      end
   end

   always_comb begin
      case (tgt)
         TGT_SYS:  wb_up.rdt = wb_sys.rdt;
         TGT_GPIO: wb_up.rdt = wb_gpio.rdt;
         default:  wb_up.rdt = '0;
      endcase
   end

   assign wb_up.ack = ((tgt == TGT_SYS) && wb_sys.ack) || ((tgt == TGT_GPIO) && wb_gpio.ack);
   assign wb_up.err = err_q;

   a_one_tgt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0({wb_sys.stb, wb_gpio.stb}));

endmodule

`default_nettype wire

// ==== design/sys_regs.sv ====
// System control registers
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
   input  logic i_clk,
   input  logic i_rst_n,
   wb_if.target wb,
   input  logic i_ram_init_done,
   input  logic i_ram_init_error
);
   import io_bus_pkg::*;

   logic [3:0]        ofs;
   logic              req;
   logic [DATA_W-1:0] scratch;
   logic [DATA_W-1:0] rd_word;
   logic              ack_q;
   logic [DATA_W-1:0] rdt_q;

   assign ofs = wb.adr[5:2];
   assign req = wb.cyc && wb.stb && !ack_q;

   always_comb begin
      case (ofs)
         SYS_VERSION_OFS: rd_word = SYS_VERSION;
         SYS_SCRATCH_OFS: rd_word = scratch;
         SYS_STATUS_OFS:  rd_word = {{(DATA_W-2){1'b0}}, i_ram_init_error, i_ram_init_done};
         default:         rd_word = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ack_q   <= 1'b0;
         scratch <= '0;
      end else begin
         ack_q <= req;
         // Byte lanes under sel
         if (req && wb.we && (ofs == SYS_SCRATCH_OFS)) begin
            for (int i = 0; i < SEL_W; i++) begin
               if (wb.sel[i]) begin
                  scratch[i*8 +: 8] <= wb.dat[i*8 +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (req) begin
         rdt_q <= rd_word;
      end
   end

   assign wb.ack = ack_q;
   assign wb.rdt = rdt_q;

endmodule

`default_nettype wire

// ==== design/gpio_regs.sv ====
// GPIO registers
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   wb_if.target                         wb,
   input  logic [io_bus_pkg::GPIO_W-1:0] i_gpio_in,
   output logic [io_bus_pkg::GPIO_W-1:0] o_gpio_out,
   output logic [io_bus_pkg::GPIO_W-1:0] o_gpio_oe
);
   import io_bus_pkg::*;

   logic [GPIO_W-1:0] in_meta;
   logic [GPIO_W-1:0] in_sync;
   logic [3:0]        ofs;
   logic              req;
   logic [DATA_W-1:0] rd_word;
   logic              ack_q;
   logic [DATA_W-1:0] rdt_q;

   assign ofs = wb.adr[5:2];
   assign req = wb.cyc && wb.stb && !ack_q;

   // Two-flop input synchroniser
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         in_meta <= '0;
         in_sync <= '0;
      end else begin
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
      end
   end

   always_comb begin
      case (ofs)
         GPIO_IN_OFS:  rd_word = in_sync;
         GPIO_OUT_OFS: rd_word = o_gpio_out;
         GPIO_OE_OFS:  rd_word = o_gpio_oe;
         default:      rd_word = '0;
      endcase
   end

   // Whole-word writes, sel ignored
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ack_q      <= 1'b0;
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
      end else begin
         ack_q <= req;
         if (req && wb.we && (ofs == GPIO_OUT_OFS)) begin
            o_gpio_out <= wb.dat;
         end
         if (req && wb.we && (ofs == GPIO_OE_OFS)) begin
            o_gpio_oe <= wb.dat;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (req) begin
         rdt_q <= rd_word;
      end
   end

   assign wb.ack = ack_q;
   assign wb.rdt = rdt_q;

   a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      wb.ack |=> !wb.ack);

endmodule

`default_nettype wire

// ==== design/io_subsystem_top.sv ====
// I/O subsystem top level
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_top (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic [io_bus_pkg::ADDR_W-1:0] i_awaddr,
   input  logic [io_bus_pkg::ID_W-1:0]   i_awid,
   input  logic                         i_awvalid,
   output logic                         o_awready,
   input  logic [io_bus_pkg::DATA_W-1:0] i_wdata,
   input  logic [io_bus_pkg::SEL_W-1:0]  i_wstrb,
   input  logic                         i_wvalid,
   output logic                         o_wready,
   output logic [io_bus_pkg::ID_W-1:0]   o_bid,
   output io_bus_pkg::axi_resp_e        o_bresp,
   output logic                         o_bvalid,
   input  logic                         i_bready,
   input  logic [io_bus_pkg::ADDR_W-1:0] i_araddr,
   input  logic [io_bus_pkg::ID_W-1:0]   i_arid,
   input  logic                         i_arvalid,
   output logic                         o_arready,
   output logic [io_bus_pkg::DATA_W-1:0] o_rdata,
   output logic [io_bus_pkg::ID_W-1:0]   o_rid,
   output io_bus_pkg::axi_resp_e        o_rresp,
   output logic                         o_rvalid,
   input  logic                         i_rready,
   input  logic                         i_ram_init_done,
   input  logic                         i_ram_init_error,
   input  logic [io_bus_pkg::GPIO_W-1:0] i_gpio_in,
   output logic [io_bus_pkg::GPIO_W-1:0] o_gpio_out,
   output logic [io_bus_pkg::GPIO_W-1:0] o_gpio_oe
);

   wb_if wb_up ();
   wb_if wb_sys ();
   wb_if wb_gpio ();

   // AXI ports connect by name
   axi_to_wb bridge_i (
      .wb (wb_up),
      .*
   );

   wb_decoder decoder_i (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .wb_up   (wb_up),
      .wb_sys  (wb_sys),
      .wb_gpio (wb_gpio)
   );

   sys_regs syscon_i (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .wb               (wb_sys),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error)
   );

   gpio_regs gpio_i (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .wb         (wb_gpio),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe)
   );

endmodule

`default_nettype wire

// ==== verif/tb_io_subsystem.sv ====
// I/O subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_io_subsystem;
   import io_bus_pkg::*;

   localparam int          RST_CYCLES  = 5;
   // Sum of the accesses issued by the test sequence below
   localparam int          N_TRANS     = 69;
   localparam int          CLK_PERIOD  = 4;
   localparam logic [31:0] SEED        = 32'h8560_d6e1;
   localparam logic [31:0] EXP_VERSION = 32'h0001_0203;
   localparam logic [1:0]  OKAY        = 2'd0;
   localparam logic [1:0]  SLVERR      = 2'd2;

   typedef struct packed {
      logic        wr;
      logic [3:0]  id;
      logic [1:0]  resp;
      logic [31:0] data;
   } exp_t;

   logic i_clk, i_rst_n;
   logic [ADDR_W-1:0] i_awaddr, i_araddr;
   logic [ID_W-1:0]   i_awid, i_arid, o_bid, o_rid;
   logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
   logic i_arvalid, o_arready, o_rvalid, i_rready;
   logic [DATA_W-1:0] i_wdata, o_rdata;
   logic [SEL_W-1:0]  i_wstrb;
   logic [1:0]        o_bresp, o_rresp;
   logic              i_ram_init_done, i_ram_init_error;
   logic [GPIO_W-1:0] i_gpio_in, o_gpio_out, o_gpio_oe;

   // Reference model state and scoreboard
   logic [31:0] m_scratch, m_out, m_oe;
   exp_t        exp_q[$];
   exp_t        cur;
   int          n_issued = 0;
   int          n_checked = 0;
   int          cyc_cnt = 0;
   int          addr_cyc = 0;
   logic        hold = 1'b0;
   logic        prev_valid = 1'b0;
   logic [31:0] held_rdata;
   logic [11:0] held_tag;
   logic [11:0] resp_tag;

   assign resp_tag = {o_bid, o_bresp, o_rid, o_rresp};

   io_subsystem_top dut_i (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_awaddr (i_awaddr), .i_awid (i_awid), .i_awvalid (i_awvalid), .o_awready (o_awready),
      .i_wdata (i_wdata), .i_wstrb (i_wstrb), .i_wvalid (i_wvalid), .o_wready (o_wready),
      .o_bid (o_bid), .o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
      .i_araddr (i_araddr), .i_arid (i_arid), .i_arvalid (i_arvalid), .o_arready (o_arready),
      .o_rdata (o_rdata), .o_rid (o_rid), .o_rresp (o_rresp), .o_rvalid (o_rvalid),
      .i_rready (i_rready),
      .i_ram_init_done (i_ram_init_done), .i_ram_init_error (i_ram_init_error),
      .i_gpio_in (i_gpio_in), .o_gpio_out (o_gpio_out), .o_gpio_oe (o_gpio_oe)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cyc_cnt <= cyc_cnt + 1;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      if (got !== want) begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   // Expected response from the register map
   function automatic exp_t predict_response(
      input logic wr, input logic [15:0] addr, input logic [31:0] data,
      input logic [3:0] strb, input logic [31:0] scratch, input logic [31:0] out_word,
      input logic [31:0] oe_word, input logic done, input logic error,
      input logic [31:0] pins
   );
      exp_t e;
      e = '0;
      e.wr = wr;
      e.resp = OKAY;
      if (addr[15:12] > 4'd1) begin
         e.resp = SLVERR;
      end else if (!wr) begin
         case ({addr[12], addr[5:2]})
            5'h00:   e.data = EXP_VERSION;
            5'h01:   e.data = scratch;
            5'h02:   e.data = {30'd0, error, done};
            5'h10:   e.data = pins;
            5'h11:   e.data = out_word;
            5'h12:   e.data = oe_word;
            default: e.data = 32'd0;
         endcase
      end
      return e;
   endfunction

   task automatic record_expected(input logic wr, input logic [15:0] addr,
                                  input logic [31:0] data, input logic [3:0] strb,
                                  input logic [3:0] id);
      exp_t e;
      e = predict_response(wr, addr, data, strb, m_scratch, m_out, m_oe,
                           i_ram_init_done, i_ram_init_error, i_gpio_in);
      e.id = id;
      exp_q.push_back(e);
      n_issued++;
      if (wr && addr[15:12] == 4'd0 && addr[5:2] == 4'd1) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               m_scratch[b*8 +: 8] = data[b*8 +: 8];
            end
         end
      end
      if (wr && addr[15:12] == 4'd1 && addr[5:2] == 4'd1) begin
         m_out = data;
      end
      if (wr && addr[15:12] == 4'd1 && addr[5:2] == 4'd2) begin
         m_oe = data;
      end
   endtask

   function automatic logic [15:0] make_addr(input logic [3:0] page, input logic [3:0] ofs);
      return {page, 6'($urandom), ofs, 2'b00};
   endfunction

   task automatic write_access(input logic [15:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input logic [3:0] id);
      int delay;
      delay = $urandom_range(5, 0);
      @(posedge i_clk);
      #1;
      i_awaddr  = addr;
      i_awid    = id;
      i_wdata   = data;
      i_wstrb   = strb;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      @(negedge i_clk);
      while (!o_awready) begin
         @(negedge i_clk);
      end
      compare_value("o_wready", 32'(o_wready), 32'd1);
      record_expected(1'b1, addr, data, strb, id);
      @(posedge i_clk);
      #1;
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      while (!o_bvalid) begin
         @(negedge i_clk);
      end
      // Back-pressure on B
      repeat (delay) @(posedge i_clk);
      @(posedge i_clk);
      #1;
      i_bready = 1'b1;
      @(posedge i_clk);
      #1;
      i_bready = 1'b0;
   endtask

   task automatic read_access(input logic [15:0] addr, input logic [3:0] id);
      int delay;
      delay = $urandom_range(5, 0);
      @(posedge i_clk);
      #1;
      i_araddr  = addr;
      i_arid    = id;
      i_arvalid = 1'b1;
      @(negedge i_clk);
      while (!o_arready) begin
         @(negedge i_clk);
      end
      record_expected(1'b0, addr, 32'd0, 4'hf, id);
      @(posedge i_clk);
      #1;
      i_arvalid = 1'b0;
      while (!o_rvalid) begin
         @(negedge i_clk);
      end
      repeat (delay) @(posedge i_clk);
      @(posedge i_clk);
      #1;
      i_rready = 1'b1;
      @(posedge i_clk);
      #1;
      i_rready = 1'b0;
   endtask

   // ************************************************************
   // Response checking and protocol timing
   // ************************************************************
   always @(negedge i_clk) begin
      if (i_rst_n) begin
         if (hold) begin
            compare_value("o_bvalid|o_rvalid", 32'(o_bvalid || o_rvalid), 32'd1);
            compare_value("o_rdata", o_rdata, held_rdata);
            compare_value("{o_bid,o_bresp,o_rid,o_rresp}", 32'(resp_tag), 32'(held_tag));
         end
         if (o_bvalid || o_rvalid) begin
            compare_value("o_awready", 32'(o_awready), 32'd0);
            compare_value("o_wready", 32'(o_wready), 32'd0);
            compare_value("o_arready", 32'(o_arready), 32'd0);
            if (!prev_valid) begin
               compare_value("address-to-valid cycles", 32'(cyc_cnt - addr_cyc), 32'd3);
            end
         end
         if ((o_awready && i_awvalid) || (o_arready && i_arvalid)) begin
            addr_cyc = cyc_cnt;
         end
         if ((o_bvalid && i_bready) || (o_rvalid && i_rready)) begin
            if (exp_q.size() == 0) begin
               $display("A response arrived while no request was pending");
               $display("Something failed");
               $fatal(1);
            end
            cur = exp_q.pop_front();
            compare_value("o_bvalid", 32'(o_bvalid), 32'(cur.wr));
            if (o_bvalid) begin
               compare_value("o_bid", 32'(o_bid), 32'(cur.id));
               compare_value("o_bresp", 32'(o_bresp), 32'(cur.resp));
               compare_value("o_gpio_out", o_gpio_out, m_out);
               compare_value("o_gpio_oe", o_gpio_oe, m_oe);
            end else begin
               compare_value("o_rid", 32'(o_rid), 32'(cur.id));
               compare_value("o_rresp", 32'(o_rresp), 32'(cur.resp));
               compare_value("o_rdata", o_rdata, cur.data);
            end
            n_checked++;
         end
         hold       = (o_bvalid && !i_bready) || (o_rvalid && !i_rready);
         prev_valid = o_bvalid || o_rvalid;
         held_rdata = o_rdata;
         held_tag   = resp_tag;
      end
   end

   // Watchdog
   initial begin
      #((RST_CYCLES + N_TRANS * 20) * CLK_PERIOD);
      $display("Timeout: the run did not finish in the expected time");
      $display("Something failed");
      $fatal(1);
   end

   // ************************************************************
   // Test sequence
   // ************************************************************
   initial begin
      logic [3:0] page;
      logic [3:0] ofs;
      void'($urandom(SEED));
      i_clk = 1'b0;
      i_rst_n = 1'b0;
      i_awaddr = '0;
      i_awid = '0;
      i_awvalid = 1'b0;
      i_wdata = '0;
      i_wstrb = '0;
      i_wvalid = 1'b0;
      i_bready = 1'b0;
      i_araddr = '0;
      i_arid = '0;
      i_arvalid = 1'b0;
      i_rready = 1'b0;
      i_ram_init_done = 1'b0;
      i_ram_init_error = 1'b0;
      i_gpio_in = '0;
      m_scratch = '0;
      m_out = '0;
      m_oe = '0;
      repeat (RST_CYCLES) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      @(negedge i_clk);
      compare_value("ready/valid after reset",
                    32'({o_awready, o_wready, o_arready, o_bvalid, o_rvalid}), 32'd0);
      compare_value("o_gpio_out", o_gpio_out, 32'd0);
      compare_value("o_gpio_oe", o_gpio_oe, 32'd0);

      // Version and status across init levels
      for (int i = 0; i < 4; i++) begin
         @(posedge i_clk);
         #1;
         i_ram_init_done  = i[0];
         i_ram_init_error = i[1];
         read_access(make_addr(4'd0, 4'd0), 4'(i));
         read_access(make_addr(4'd0, 4'd2), 4'(i + 8));
      end

      repeat (8) begin
         write_access(make_addr(4'd0, 4'd1), $urandom, 4'($urandom), 4'($urandom));
         read_access(make_addr(4'd0, 4'd1), 4'($urandom));
      end

      repeat (4) begin
         write_access(make_addr(4'd1, 4'd1), $urandom, 4'($urandom), 4'($urandom));
         write_access(make_addr(4'd1, 4'd2), $urandom, 4'($urandom), 4'($urandom));
         read_access(make_addr(4'd1, 4'd1), 4'($urandom));
         read_access(make_addr(4'd1, 4'd2), 4'($urandom));
         @(posedge i_clk);
         #1;
         i_gpio_in = $urandom;
         repeat (3) @(posedge i_clk);
         read_access(make_addr(4'd1, 4'd0), 4'($urandom));
      end

      // Unmapped pages, then unmapped offsets
      repeat (4) begin
         page = 4'($urandom_range(15, 2));
         write_access(make_addr(page, 4'($urandom)), $urandom, 4'hf, 4'($urandom));
         read_access(make_addr(page, 4'($urandom)), 4'($urandom));
         page = 4'($urandom_range(1, 0));
         ofs  = 4'($urandom_range(15, 3));
         write_access(make_addr(page, ofs), $urandom, 4'hf, 4'($urandom));
         read_access(make_addr(page, ofs), 4'($urandom));
      end
      read_access(make_addr(4'd0, 4'd1), 4'd5);
      read_access(make_addr(4'd1, 4'd1), 4'd6);
      read_access(make_addr(4'd1, 4'd2), 4'd7);

      // Write and read presented together
      repeat (2) begin
         fork
            write_access(make_addr(4'd0, 4'd1), $urandom, 4'hf, 4'd3);
            read_access(make_addr(4'd0, 4'd1), 4'd12);
         join
      end

      // Write arriving while a read is in flight
      fork
         read_access(make_addr(4'd0, 4'd1), 4'd9);
         begin
            @(posedge i_clk);
            write_access(make_addr(4'd0, 4'd1), $urandom, 4'($urandom), 4'd10);
         end
      join

      @(negedge i_clk);
      if (exp_q.size() == 0 && n_checked == n_issued) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Responses missing: %0d issued, %0d checked", n_issued, n_checked);
         $display("Something failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== flist.f ====
design/io_bus_pkg.sv
design/wb_if.sv
design/axi_to_wb.sv
design/wb_decoder.sv
design/sys_regs.sv
design/gpio_regs.sv
design/io_subsystem_top.sv
verif/tb_io_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
   --top-module tb_io_subsystem -o tb_io_subsystem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/tb_io_subsystem 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1
